// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_regfile
RTL_TOP    := regfile_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== apb_reg_decode.sv ====
// APB register decode
`timescale 1ns/1ps

module apb_reg_decode #(
    parameter int ADDR_WIDTH = 21
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [ADDR_WIDTH-1:0]   paddr,
    input  logic                    pwrite,
    input  logic                    psel,
    input  logic                    penable,
    input  regfile_pkg::word_t      pwdata,
    output logic                    pready,
    output regfile_pkg::word_t      prdata,

    reg_bank_if.decode              cfg_bus,
    reg_bank_if.decode              mdio_bus
);

    localparam int IDX_W    = regfile_pkg::BANK_IDX_WIDTH;
    localparam int NUM_REGS = 2 ** $bits(regfile_pkg::reg_addr_t);

    logic                   access;
    logic                   in_map;
    logic                   hit;
    logic                   bank_sel;
    logic                   wr_hit;
    logic                   rd_hit;
    regfile_pkg::bank_idx_t local_idx;

    // ------------------------------------------------------------
    // Access phase and map hit
    // ------------------------------------------------------------
    assign access    = psel & penable;
    assign in_map    = paddr < ADDR_WIDTH'(NUM_REGS);
    assign hit       = access & in_map;
    assign wr_hit    = hit & pwrite;
    assign rd_hit    = hit & ~pwrite;

    // Bank bit sits right above the local index
    assign bank_sel  = paddr[IDX_W];
    assign local_idx = paddr[IDX_W-1:0];

    // No wait states
    assign pready    = access;

    // ------------------------------------------------------------
    // Bank requests
    // ------------------------------------------------------------
    assign cfg_bus.wr_en  = wr_hit & (bank_sel == regfile_pkg::BANK_CFG);
    assign cfg_bus.idx    = local_idx;
    assign cfg_bus.wdata  = pwdata;

    assign mdio_bus.wr_en = wr_hit & (bank_sel == regfile_pkg::BANK_MDIO);
    assign mdio_bus.idx   = local_idx;
    assign mdio_bus.wdata = pwdata;

    // ------------------------------------------------------------
    // Read return
    // ------------------------------------------------------------
    always_comb begin
        prdata = '0;
        if (rd_hit) begin
            if (bank_sel == regfile_pkg::BANK_MDIO) begin
                prdata = mdio_bus.rdata;
            end else begin
                prdata = cfg_bus.rdata;
            end
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Master protocol on the APB inputs
    a_setup_then_access: assert property (
        @(posedge clk) disable iff (!arst_n)
        psel && !penable |=> psel && penable
    );

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!arst_n)
        penable |-> psel
    );

endmodule

// ==== cfg_regs.sv ====
// Link and packet configuration bank
`timescale 1ns/1ps

module cfg_regs (
    input  logic                    clk,
    input  logic                    arst_n,

    reg_bank_if.bank                bus,

    output regfile_pkg::phy_addr_t  legal_phy_addr,
    output regfile_pkg::phy_addr_t  legal_phy_addr_mask,
    output regfile_pkg::phy_addr_t  broadcast_addr,
    output logic                    broadcast_mode,
    output logic                    non_zero_detect,
    output logic                    opendrain_mode,
    output logic                    watchdog_enable,
    output logic                    sync_select,
    output logic                    rf_self_test_mode,
    output regfile_pkg::pkt_len_t   rf_pkt_data_length,
    output logic                    rf_capture_mode,
    output logic                    rf_capture_start,
    output logic                    rf_capture_again,
    output logic                    rf_96path_en,
    output regfile_pkg::idle_len_t  rf_pkt_idle_length
);

    regfile_pkg::link_mode_t link_mode_q;

    logic wr_link_id;
    logic wr_link_mode;
    logic wr_pkt_ctrl;
    logic wr_pkt_idle;

    // ------------------------------------------------------------
    // Write strobes per word
    // ------------------------------------------------------------
    assign wr_link_id   = bus.wr_en &&
                          bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_LINK_ID);
    assign wr_link_mode = bus.wr_en &&
                          bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_LINK_MODE);
    assign wr_pkt_ctrl  = bus.wr_en &&
                          bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_PKT_CTRL);
    assign wr_pkt_idle  = bus.wr_en &&
                          bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_PKT_IDLE);

    // ------------------------------------------------------------
    // Field registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            legal_phy_addr      <= regfile_pkg::RST_PHY_ADDR;
            legal_phy_addr_mask <= regfile_pkg::RST_PHY_ADDR;
            broadcast_addr      <= regfile_pkg::RST_PHY_ADDR;
            link_mode_q         <= regfile_pkg::RST_LINK_MODE;
            rf_self_test_mode   <= 1'b0;
            rf_pkt_data_length  <= '0;
            rf_capture_mode     <= 1'b0;
            rf_96path_en        <= regfile_pkg::RST_96PATH;
            rf_pkt_idle_length  <= regfile_pkg::RST_IDLE_LEN;
        end else begin
            if (wr_link_id) begin
                legal_phy_addr      <= bus.wdata[14:10];
                legal_phy_addr_mask <= bus.wdata[9:5];
                broadcast_addr      <= bus.wdata[4:0];
            end
            if (wr_link_mode) begin
                link_mode_q <= regfile_pkg::link_mode_t'(bus.wdata[4:0]);
            end
            if (wr_pkt_ctrl) begin
                rf_self_test_mode  <= bus.wdata[6];
                rf_pkt_data_length <= bus.wdata[5:4];
                rf_capture_mode    <= bus.wdata[3];
                rf_96path_en       <= bus.wdata[0];
            end
            if (wr_pkt_idle) begin
                rf_pkt_idle_length <= bus.wdata;
            end
        end
    end

    // Capture strobes last one cycle after the write edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rf_capture_start <= 1'b0;
            rf_capture_again <= 1'b0;
        end else begin
            rf_capture_start <= wr_pkt_ctrl & bus.wdata[2];
            rf_capture_again <= wr_pkt_ctrl & bus.wdata[1];
        end
    end

    assign broadcast_mode  = link_mode_q.broadcast_mode;
    assign non_zero_detect = link_mode_q.non_zero_detect;
    assign opendrain_mode  = link_mode_q.opendrain_mode;
    assign watchdog_enable = link_mode_q.watchdog_enable;
    assign sync_select     = link_mode_q.sync_select;

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb begin
        case (bus.idx)
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_LINK_ID):
                bus.rdata = {1'b0, legal_phy_addr, legal_phy_addr_mask, broadcast_addr};
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_LINK_MODE):
                bus.rdata = {11'h0, link_mode_q};
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_PKT_CTRL):
                // Strobe bits 2 and 1 read as zero
                bus.rdata = {9'h0, rf_self_test_mode, rf_pkt_data_length,
                             rf_capture_mode, 2'b00, rf_96path_en};
            default:
                bus.rdata = rf_pkt_idle_length;
        endcase
    end

    a_capture_start_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        rf_capture_start |=> !rf_capture_start
    );

    a_capture_again_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        rf_capture_again |=> !rf_capture_again
    );

endmodule

// ==== mdio_regs.sv ====
// MDIO access bank
`timescale 1ns/1ps

module mdio_regs (
    input  logic                        clk,
    input  logic                        arst_n,

    reg_bank_if.bank                    bus,

    input  regfile_pkg::mdio_data_t     rf_mdio_pkt_data,
    input  logic                        rf_mdio_pkt_data_we,

    output regfile_pkg::mdio_mem_addr_t rf_mdio_memory_addr,
    output regfile_pkg::mdio_sel_t      rf_mdio_data_sel,
    output logic                        rf_mdio_read_pulse
);

    regfile_pkg::mdio_data_t pkt_data_q;

    logic wr_mem_addr;
    logic wr_data_sel;
    logic wr_read;

    // ------------------------------------------------------------
    // Write strobes per word
    // ------------------------------------------------------------
    // 0x6 has no bus strobe, the device side owns it
    assign wr_mem_addr = bus.wr_en &&
                         bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_ADDR);
    assign wr_data_sel = bus.wr_en &&
                         bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_SEL);
    assign wr_read     = bus.wr_en &&
                         bus.idx == regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_READ);

    // ------------------------------------------------------------
    // Field registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rf_mdio_memory_addr <= '0;
            rf_mdio_data_sel    <= '0;
        end else begin
            if (wr_mem_addr) begin
                rf_mdio_memory_addr <= bus.wdata[14:0];
            end
            if (wr_data_sel) begin
                rf_mdio_data_sel <= bus.wdata[6:0];
            end
        end
    end

    // Device capture, never stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_data_q <= '0;
        end else if (rf_mdio_pkt_data_we) begin
            pkt_data_q <= rf_mdio_pkt_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rf_mdio_read_pulse <= 1'b0;
        end else begin
            rf_mdio_read_pulse <= wr_read & bus.wdata[0];
        end
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb begin
        case (bus.idx)
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_ADDR):
                bus.rdata = {1'b0, rf_mdio_memory_addr};
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_SEL):
                bus.rdata = {9'h0, rf_mdio_data_sel};
            regfile_pkg::bank_idx_t'(regfile_pkg::ADDR_MDIO_DATA):
                bus.rdata = {7'h0, pkt_data_q};
            default:
                // Read strobe word
                bus.rdata = '0;
        endcase
    end

    a_read_pulse_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        rf_mdio_read_pulse |=> !rf_mdio_read_pulse
    );

endmodule

// ==== reg_bank_if.sv ====
// Decoder to register bank link
`timescale 1ns/1ps

interface reg_bank_if;

    logic                   wr_en;
    regfile_pkg::bank_idx_t idx;
    regfile_pkg::word_t     wdata;
    regfile_pkg::word_t     rdata;

    modport decode (
        output wr_en,
        output idx,
        output wdata,
        input  rdata
    );

    modport bank (
        input  wr_en,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface

// ==== regfile_pkg.sv ====
// PHY register file definitions
package regfile_pkg;

    // ------------------------------------------------------------
    // Widths and types
    // ------------------------------------------------------------
    localparam int DATA_WIDTH     = 16;
    localparam int BANK_IDX_WIDTH = 2;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;

    // Word address within the map, bank bit on top of the local index
    typedef logic [BANK_IDX_WIDTH:0]   reg_addr_t;

    typedef logic [4:0]  phy_addr_t;
    typedef logic [1:0]  pkt_len_t;
    typedef logic [15:0] idle_len_t;
    typedef logic [14:0] mdio_mem_addr_t;
    typedef logic [6:0]  mdio_sel_t;
    typedef logic [8:0]  mdio_data_t;

    // Mode bits of 0x1, bit 4 down to bit 0
    typedef struct packed {
        logic broadcast_mode;
        logic non_zero_detect;
        logic opendrain_mode;
        logic watchdog_enable;
        logic sync_select;
    } link_mode_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam logic BANK_CFG  = 1'b0;
    localparam logic BANK_MDIO = 1'b1;

    localparam reg_addr_t ADDR_LINK_ID   = 3'h0;
    localparam reg_addr_t ADDR_LINK_MODE = 3'h1;
    localparam reg_addr_t ADDR_PKT_CTRL  = 3'h2;
    localparam reg_addr_t ADDR_PKT_IDLE  = 3'h3;
    localparam reg_addr_t ADDR_MDIO_ADDR = 3'h4;
    localparam reg_addr_t ADDR_MDIO_SEL  = 3'h5;
    localparam reg_addr_t ADDR_MDIO_DATA = 3'h6;
    localparam reg_addr_t ADDR_MDIO_READ = 3'h7;

    // ------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------
    localparam phy_addr_t  RST_PHY_ADDR  = 5'h1f;
    localparam link_mode_t RST_LINK_MODE = '{
        broadcast_mode : 1'b1,
        opendrain_mode : 1'b1,
        default        : 1'b0
    };
    localparam logic       RST_96PATH    = 1'b1;
    localparam idle_len_t  RST_IDLE_LEN  = 16'h7fff;

endpackage

// ==== regfile_top.sv ====
// PHY packet controller register file
`timescale 1ns/1ps

module regfile_top #(
    parameter int ADDR_WIDTH = 21
) (
    input  logic                        clk,
    input  logic                        arst_n,

    // APB slave
    input  logic [ADDR_WIDTH-1:0]       req_paddr,
    input  logic                        req_pwrite,
    input  logic                        req_psel,
    input  logic                        req_penable,
    input  regfile_pkg::word_t          req_pwdata,
    output logic                        req_pready,
    output regfile_pkg::word_t          req_prdata,

    // Link configuration
    output regfile_pkg::phy_addr_t      legal_phy_addr,
    output regfile_pkg::phy_addr_t      legal_phy_addr_mask,
    output regfile_pkg::phy_addr_t      broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,

    // Packet control
    output logic                        rf_self_test_mode,
    output regfile_pkg::pkt_len_t       rf_pkt_data_length,
    output logic                        rf_capture_mode,
    output logic                        rf_capture_start,
    output logic                        rf_capture_again,
    output logic                        rf_96path_en,
    output regfile_pkg::idle_len_t      rf_pkt_idle_length,

    // MDIO access
    output regfile_pkg::mdio_mem_addr_t rf_mdio_memory_addr,
    output regfile_pkg::mdio_sel_t      rf_mdio_data_sel,
    output logic                        rf_mdio_read_pulse,
    input  regfile_pkg::mdio_data_t     rf_mdio_pkt_data,
    input  logic                        rf_mdio_pkt_data_we
);

    reg_bank_if cfg_bus ();
    reg_bank_if mdio_bus ();

    apb_reg_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .paddr    (req_paddr),
        .pwrite   (req_pwrite),
        .psel     (req_psel),
        .penable  (req_penable),
        .pwdata   (req_pwdata),
        .pready   (req_pready),
        .prdata   (req_prdata),
        .cfg_bus  (cfg_bus),
        .mdio_bus (mdio_bus)
    );

    cfg_regs u_cfg_regs (
        .clk                 (clk),
        .arst_n              (arst_n),
        .bus                 (cfg_bus),
        .legal_phy_addr      (legal_phy_addr),
        .legal_phy_addr_mask (legal_phy_addr_mask),
        .broadcast_addr      (broadcast_addr),
        .broadcast_mode      (broadcast_mode),
        .non_zero_detect     (non_zero_detect),
        .opendrain_mode      (opendrain_mode),
        .watchdog_enable     (watchdog_enable),
        .sync_select         (sync_select),
        .rf_self_test_mode   (rf_self_test_mode),
        .rf_pkt_data_length  (rf_pkt_data_length),
        .rf_capture_mode     (rf_capture_mode),
        .rf_capture_start    (rf_capture_start),
        .rf_capture_again    (rf_capture_again),
        .rf_96path_en        (rf_96path_en),
        .rf_pkt_idle_length  (rf_pkt_idle_length)
    );

    mdio_regs u_mdio_regs (
        .clk                 (clk),
        .arst_n              (arst_n),
        .bus                 (mdio_bus),
        .rf_mdio_pkt_data    (rf_mdio_pkt_data),
        .rf_mdio_pkt_data_we (rf_mdio_pkt_data_we),
        .rf_mdio_memory_addr (rf_mdio_memory_addr),
        .rf_mdio_data_sel    (rf_mdio_data_sel),
        .rf_mdio_read_pulse  (rf_mdio_read_pulse)
    );

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// ==== tb_regfile.sv ====
// Register file testbench
`timescale 1ns/1ps

module tb_regfile;

    localparam int ADDR_WIDTH = 21;
    localparam int SAMPLE_DLY = 5;
    localparam int NUM_WRITES = 200;
    // Worst case is about 2450 cycles for 200 rounds of up to 12
    localparam int CYCLE_LIMIT = 3000;
    localparam logic [31:0] LFSR_SEED = 32'hb9fdb11a;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                        clk;
    logic                        arst_n;
    logic [ADDR_WIDTH-1:0]       req_paddr;
    logic                        req_pwrite;
    logic                        req_psel;
    logic                        req_penable;
    regfile_pkg::word_t          req_pwdata;
    logic                        req_pready;
    regfile_pkg::word_t          req_prdata;
    regfile_pkg::phy_addr_t      legal_phy_addr;
    regfile_pkg::phy_addr_t      legal_phy_addr_mask;
    regfile_pkg::phy_addr_t      broadcast_addr;
    logic                        broadcast_mode;
    logic                        non_zero_detect;
    logic                        opendrain_mode;
    logic                        watchdog_enable;
    logic                        sync_select;
    logic                        rf_self_test_mode;
    regfile_pkg::pkt_len_t       rf_pkt_data_length;
    logic                        rf_capture_mode;
    logic                        rf_capture_start;
    logic                        rf_capture_again;
    logic                        rf_96path_en;
    regfile_pkg::idle_len_t      rf_pkt_idle_length;
    regfile_pkg::mdio_mem_addr_t rf_mdio_memory_addr;
    regfile_pkg::mdio_sel_t      rf_mdio_data_sel;
    logic                        rf_mdio_read_pulse;
    regfile_pkg::mdio_data_t     rf_mdio_pkt_data;
    logic                        rf_mdio_pkt_data_we;

    // Shadow model with one word per address
    regfile_pkg::word_t model [8];
    logic               exp_cap_start;
    logic               exp_cap_again;
    logic               exp_read_pulse;
    logic [31:0]        lfsr_state = LFSR_SEED;
    int unsigned        cycle_count = 0;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    regfile_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut0 (
        .clk                 (clk),
        .arst_n              (arst_n),
        .req_paddr           (req_paddr),
        .req_pwrite          (req_pwrite),
        .req_psel            (req_psel),
        .req_penable         (req_penable),
        .req_pwdata          (req_pwdata),
        .req_pready          (req_pready),
        .req_prdata          (req_prdata),
        .legal_phy_addr      (legal_phy_addr),
        .legal_phy_addr_mask (legal_phy_addr_mask),
        .broadcast_addr      (broadcast_addr),
        .broadcast_mode      (broadcast_mode),
        .non_zero_detect     (non_zero_detect),
        .opendrain_mode      (opendrain_mode),
        .watchdog_enable     (watchdog_enable),
        .sync_select         (sync_select),
        .rf_self_test_mode   (rf_self_test_mode),
        .rf_pkt_data_length  (rf_pkt_data_length),
        .rf_capture_mode     (rf_capture_mode),
        .rf_capture_start    (rf_capture_start),
        .rf_capture_again    (rf_capture_again),
        .rf_96path_en        (rf_96path_en),
        .rf_pkt_idle_length  (rf_pkt_idle_length),
        .rf_mdio_memory_addr (rf_mdio_memory_addr),
        .rf_mdio_data_sel    (rf_mdio_data_sel),
        .rf_mdio_read_pulse  (rf_mdio_read_pulse),
        .rf_mdio_pkt_data    (rf_mdio_pkt_data),
        .rf_mdio_pkt_data_we (rf_mdio_pkt_data_we)
    );

    // ------------------------------------------------------------
    // Random numbers and model helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // Implemented bits per word with strobes and 0x7 reading zero
    function automatic regfile_pkg::word_t read_mask(input logic [2:0] addr);
        case (addr)
            3'd0:    return 16'h7fff;
            3'd1:    return 16'h001f;
            3'd2:    return 16'h0079;
            3'd3:    return 16'hffff;
            3'd4:    return 16'h7fff;
            3'd5:    return 16'h007f;
            3'd6:    return 16'h01ff;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic model_write(input logic [ADDR_WIDTH-1:0] addr, input regfile_pkg::word_t data);
        if (addr[ADDR_WIDTH-1:3] == '0) begin
            if (addr[2:0] == 3'd2) begin
                exp_cap_start = data[2];
                exp_cap_again = data[1];
            end
            if (addr[2:0] == 3'd7) begin
                exp_read_pulse = data[0];
            end
            // Device side owns 0x6
            if (addr[2:0] != 3'd6) begin
                model[addr[2:0]] = data & read_mask(addr[2:0]);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_outputs();
        compare("legal_phy_addr", 32'(legal_phy_addr), 32'(model[0][14:10]));
        compare("legal_phy_addr_mask", 32'(legal_phy_addr_mask), 32'(model[0][9:5]));
        compare("broadcast_addr", 32'(broadcast_addr), 32'(model[0][4:0]));
        compare("broadcast_mode", 32'(broadcast_mode), 32'(model[1][4]));
        compare("non_zero_detect", 32'(non_zero_detect), 32'(model[1][3]));
        compare("opendrain_mode", 32'(opendrain_mode), 32'(model[1][2]));
        compare("watchdog_enable", 32'(watchdog_enable), 32'(model[1][1]));
        compare("sync_select", 32'(sync_select), 32'(model[1][0]));
        compare("rf_self_test_mode", 32'(rf_self_test_mode), 32'(model[2][6]));
        compare("rf_pkt_data_length", 32'(rf_pkt_data_length), 32'(model[2][5:4]));
        compare("rf_capture_mode", 32'(rf_capture_mode), 32'(model[2][3]));
        compare("rf_96path_en", 32'(rf_96path_en), 32'(model[2][0]));
        compare("rf_capture_start", 32'(rf_capture_start), 32'(exp_cap_start));
        compare("rf_capture_again", 32'(rf_capture_again), 32'(exp_cap_again));
        compare("rf_pkt_idle_length", 32'(rf_pkt_idle_length), 32'(model[3]));
        compare("rf_mdio_memory_addr", 32'(rf_mdio_memory_addr), 32'(model[4][14:0]));
        compare("rf_mdio_data_sel", 32'(rf_mdio_data_sel), 32'(model[5][6:0]));
        compare("rf_mdio_read_pulse", 32'(rf_mdio_read_pulse), 32'(exp_read_pulse));
    endtask

    // Outside an access phase
    task automatic check_no_access();
        compare("req_pready", 32'(req_pready), 32'd0);
        compare("req_prdata", 32'(req_prdata), 32'd0);
    endtask

    // Pulses are only valid for the first cycle after the write edge
    task automatic tick();
        @(negedge clk);
        check_outputs();
        exp_cap_start = 1'b0;
        exp_cap_again = 1'b0;
        exp_read_pulse = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Bus and device operations
    // ------------------------------------------------------------
    task automatic bus_idle();
        req_psel = 1'b0;
        req_penable = 1'b0;
        req_pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input regfile_pkg::word_t data);
        req_paddr = addr;
        req_pwrite = 1'b1;
        req_psel = 1'b1;
        req_penable = 1'b0;
        req_pwdata = data;
        #SAMPLE_DLY;
        check_no_access();
        tick();
        req_penable = 1'b1;
        #SAMPLE_DLY;
        compare("req_pready", 32'(req_pready), 32'd1);
        compare("req_prdata", 32'(req_prdata), 32'd0);
        model_write(addr, data);
        tick();
        bus_idle();
    endtask

    task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr);
        regfile_pkg::word_t expected;
        expected = '0;
        if (addr[ADDR_WIDTH-1:3] == '0) begin
            expected = model[addr[2:0]];
        end
        req_paddr = addr;
        req_pwrite = 1'b0;
        req_psel = 1'b1;
        req_penable = 1'b0;
        #SAMPLE_DLY;
        check_no_access();
        tick();
        req_penable = 1'b1;
        #SAMPLE_DLY;
        compare("req_pready", 32'(req_pready), 32'd1);
        compare("req_prdata", 32'(req_prdata), 32'(expected));
        tick();
        bus_idle();
    endtask

    task automatic idle_cycle(input logic [ADDR_WIDTH-1:0] addr);
        bus_idle();
        req_paddr = addr;
        #SAMPLE_DLY;
        check_no_access();
        tick();
    endtask

    task automatic device_write(input regfile_pkg::mdio_data_t data);
        bus_idle();
        rf_mdio_pkt_data = data;
        rf_mdio_pkt_data_we = 1'b1;
        model[6] = 16'(data);
        #SAMPLE_DLY;
        check_no_access();
        tick();
        rf_mdio_pkt_data_we = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        int                    a;
        int                    i;
        logic [2:0]            addr;
        logic [17:0]           hi;
        logic [ADDR_WIDTH-1:0] far_addr;

        req_paddr = '0;
        req_pwrite = 1'b0;
        req_psel = 1'b0;
        req_penable = 1'b0;
        req_pwdata = '0;
        rf_mdio_pkt_data = '0;
        rf_mdio_pkt_data_we = 1'b0;
        exp_cap_start = 1'b0;
        exp_cap_again = 1'b0;
        exp_read_pulse = 1'b0;

        // Reset words hold 0x1f addresses, mode bits 4 and 2, 96-path and idle 0x7fff
        model[0] = 16'h7fff;
        model[1] = 16'h0014;
        model[2] = 16'h0001;
        model[3] = 16'h7fff;
        for (a = 4; a < 8; a++) begin
            model[a] = 16'h0000;
        end

        @(posedge arst_n);
        tick();
        for (a = 0; a < 8; a++) begin
            apb_read(ADDR_WIDTH'(a));
        end

        for (i = 0; i < NUM_WRITES; i++) begin
            addr = 3'(rand_bits(3));
            apb_write(ADDR_WIDTH'(addr), 16'(rand_bits(16)));
            apb_read(ADDR_WIDTH'(addr));
            if (rand_bits(2) == 32'd0) begin
                device_write(9'(rand_bits(9)));
                apb_read(ADDR_WIDTH'(6));
            end
            // Traffic outside the map
            if (rand_bits(3) == 32'd0) begin
                hi = 18'(rand_bits(18));
                if (hi == '0) begin
                    hi = 18'd1;
                end
                far_addr = {hi, 3'(rand_bits(3))};
                apb_write(far_addr, 16'(rand_bits(16)));
                apb_read(far_addr);
                idle_cycle(far_addr);
            end
        end

        for (a = 0; a < 8; a++) begin
            apb_read(ADDR_WIDTH'(a));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
regfile_pkg.sv
reg_bank_if.sv
apb_reg_decode.sv
cfg_regs.sv
mdio_regs.sv
regfile_top.sv
tb_clk_gen.sv
tb_regfile.sv
